// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= executeStageTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/alu_macros.svh ====
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// datapath word width, the design is only built and used at 32
`define DATA_WIDTH 32

// register file geometry
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

`endif

// ==== logic/aluCore.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module aluCore (
    input  logic [`DATA_WIDTH-1:0] operandA,
    input  logic [`DATA_WIDTH-1:0] operandB,
    input  aluPkg::aluCmd_e        command,
    output logic [`DATA_WIDTH-1:0] result,
    output aluPkg::aluFlags_t      flags
);

    localparam int Msb = `DATA_WIDTH - 1;

    logic [`DATA_WIDTH:0]   carryBus;
    logic [`DATA_WIDTH-1:0] sliceResult;
    logic                   isSubtract;
    logic                   isArith;
    logic                   addOverflow;
    logic                   subOverflow;
    logic                   lessThan;

    assign isSubtract = (command == aluPkg::SUB) || (command == aluPkg::SLT);
    assign isArith    = (command == aluPkg::ADD) || isSubtract;

    // chain carry-in supplies the +1 of the two's complement subtract
    assign carryBus[0] = isSubtract;

    genvar i;
    generate
        for (i = 0; i < `DATA_WIDTH; i = i + 1) begin : gSlice
            aluSlice slice_i (
                .a        (operandA[i]),
                .b        (operandB[i]),
                .carryIn  (carryBus[i]),
                .command  (command),
                .result   (sliceResult[i]),
                .carryOut (carryBus[i+1])
            );
        end
    endgenerate

    // same operand signs but the sum sign flipped
    assign addOverflow = (operandA[Msb] == operandB[Msb])
                      && (sliceResult[Msb] != operandA[Msb]);

    // differing signs and the difference took the sign of B
    assign subOverflow = (operandA[Msb] != operandB[Msb])
                      && (sliceResult[Msb] != operandA[Msb]);

    // signed compare, sign of a - b corrected by overflow
    // only meaningful while the chain is subtracting
    assign lessThan = sliceResult[Msb] ^ subOverflow;

    always_comb begin
        if (command == aluPkg::SLT) begin
            result = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
        end else begin
            result = sliceResult;
        end
    end

    // slt reports the carry of its subtraction
    assign flags.carryOut = isArith ? carryBus[`DATA_WIDTH] : 1'b0;

    always_comb begin
        case (command)
            aluPkg::ADD: begin
                flags.overflow = addOverflow;
            end
            aluPkg::SUB: begin
                flags.overflow = subOverflow;
            end
            default: begin
                flags.overflow = 1'b0;
            end
        endcase
    end

    // zero looks at the final result, after the slt override
    assign flags.zero = (result == '0);

endmodule

// ==== logic/aluPkg.sv ====
`include "alu_macros.svh"

package aluPkg;

    // command encoding, 0 through 7
    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        XOR  = 3'd2,
        SLT  = 3'd3,
        AND  = 3'd4,
        NAND = 3'd5,
        NOR  = 3'd6,
        OR   = 3'd7
    } aluCmd_e;

    // status bits that come out of the ALU next to the result
    typedef struct packed {
        logic carryOut;
        logic zero;
        logic overflow;
    } aluFlags_t;

    // one register-to-register operation
    typedef struct packed {
        aluCmd_e                    command;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
    } aluInst_t;

endpackage

// ==== logic/aluSlice.sv ====
`timescale 1ns/1ps

module aluSlice (
    input  logic            a,
    input  logic            b,
    input  logic            carryIn,
    input  aluPkg::aluCmd_e command,
    output logic            result,
    output logic            carryOut
);

    logic invertB;
    logic bEff;
    logic sum;

    // subtraction is a + ~b + 1, the +1 enters at slice 0
    assign invertB = (command == aluPkg::SUB) || (command == aluPkg::SLT);
    assign bEff    = b ^ invertB;

    // full adder
    assign sum      = a ^ bEff ^ carryIn;
    assign carryOut = (a & bEff) | (carryIn & (a ^ bEff));

    always_comb begin
        case (command)
            aluPkg::ADD,
            aluPkg::SUB,
            aluPkg::SLT: begin
                result = sum;
            end
            aluPkg::XOR: begin
                result = a ^ b;
            end
            aluPkg::AND: begin
                result = a & b;
            end
            aluPkg::NAND: begin
                result = ~(a & b);
            end
            aluPkg::NOR: begin
                result = ~(a | b);
            end
            aluPkg::OR: begin
                result = a | b;
            end
            default: begin
                result = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module executeStage (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       instValid,
    input  aluPkg::aluInst_t           inst,
    input  logic                       loadValid,
    input  logic [`REG_ADDR_WIDTH-1:0] loadAddr,
    input  logic [`DATA_WIDTH-1:0]     loadData,
    output logic                       resultValid,
    output logic [`DATA_WIDTH-1:0]     result,
    output aluPkg::aluFlags_t          flags
);

    logic [`DATA_WIDTH-1:0]     operandA;
    logic [`DATA_WIDTH-1:0]     operandB;
    logic [`DATA_WIDTH-1:0]     aluResult;
    aluPkg::aluFlags_t          aluFlags;
    logic                       writeEnable;
    logic [`REG_ADDR_WIDTH-1:0] writeAddr;
    logic [`DATA_WIDTH-1:0]     writeData;

    // one write port, writeback beats a load in the same cycle
    assign writeEnable = instValid || loadValid;
    assign writeAddr   = instValid ? inst.rd : loadAddr;
    assign writeData   = instValid ? aluResult : loadData;

    regFile regFile_i (
        .clk         (clk),
        .rstN        (rstN),
        .readAddrA   (inst.rs),
        .readAddrB   (inst.rt),
        .readDataA   (operandA),
        .readDataB   (operandB),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeData   (writeData)
    );

    aluCore aluCore_i (
        .operandA (operandA),
        .operandB (operandB),
        .command  (inst.command),
        .result   (aluResult),
        .flags    (aluFlags)
    );

    // valid is a single pulse
    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= instValid;
        end
    end

    // result and flags hold their value between instructions
    always_ff @(posedge clk) begin
        if (!rstN) begin
            result <= '0;
            flags  <= '0;
        end else if (instValid) begin
            result <= aluResult;
            flags  <= aluFlags;
        end
    end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module regFile (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrA,
    input  logic [`REG_ADDR_WIDTH-1:0] readAddrB,
    output logic [`DATA_WIDTH-1:0]     readDataA,
    output logic [`DATA_WIDTH-1:0]     readDataB,
    input  logic                       writeEnable,
    input  logic [`REG_ADDR_WIDTH-1:0] writeAddr,
    input  logic [`DATA_WIDTH-1:0]     writeData
);

    // register 0 has no storage
    logic [`DATA_WIDTH-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int idx = 1; idx < `REG_COUNT; idx++) begin
                regs[idx] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // combinational reads, so a value written at an edge is visible right after it
    always_comb begin
        if (readAddrA == '0) begin
            readDataA = '0;
        end else begin
            readDataA = regs[readAddrA];
        end
    end

    always_comb begin
        if (readAddrB == '0) begin
            readDataB = '0;
        end else begin
            readDataB = regs[readAddrB];
        end
    end

endmodule

// ==== testbench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    localparam time HalfPeriod = 4ns;

    initial begin
        clk = 1'b0;
        forever #(HalfPeriod) clk = ~clk;
    end

    // reset held low over three rising edges, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

// ==== testbench/executeStageTb.sv ====
`timescale 1ns/1ps
`include "alu_macros.svh"

module executeStageTb;

    localparam int WaitLimit = 20;
    localparam int Msb = `DATA_WIDTH - 1;

    logic                       clk;
    logic                       rstN;
    logic                       instValid;
    aluPkg::aluInst_t           inst;
    logic                       loadValid;
    logic [`REG_ADDR_WIDTH-1:0] loadAddr;
    logic [`DATA_WIDTH-1:0]     loadData;
    logic                       resultValid;
    logic [`DATA_WIDTH-1:0]     result;
    aluPkg::aluFlags_t          flags;

    // model registers and the prediction for the instruction being driven
    logic [`DATA_WIDTH-1:0] modelRegs [0:`REG_COUNT-1];
    logic [`DATA_WIDTH-1:0] expResult;
    aluPkg::aluFlags_t      expFlags;
    logic [`DATA_WIDTH-1:0] checkResult;
    aluPkg::aluFlags_t      checkFlags;

    int assertErrors;
    int waitErrors;
    int errorBase;
    int issuedCount;
    int testCount;

    clockGen clockGen_i (.clk(clk), .rstN(rstN));

    executeStage executeStage_i (
        .clk         (clk),
        .rstN        (rstN),
        .instValid   (instValid),
        .inst        (inst),
        .loadValid   (loadValid),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .resultValid (resultValid),
        .result      (result),
        .flags       (flags)
    );

    // expected values follow the instruction through its edge
    always @(posedge clk) begin
        if (instValid) begin
            checkResult <= expResult;
            checkFlags  <= expFlags;
        end
    end

    resultCheck: assert property (@(posedge clk) disable iff (!rstN)
        instValid |=> (result == checkResult) && (flags == checkFlags))
    else begin
        $display("CHECK FAILED at %0t: result %h flags %b, expected %h flags %b", $time,
                 $sampled(result), $sampled(flags), $sampled(checkResult), $sampled(checkFlags));
        assertErrors++;
    end

    validRiseCheck: assert property (@(posedge clk) disable iff (!rstN)
        instValid |=> resultValid)
    else begin
        $display("CHECK FAILED at %0t: resultValid missing after instValid", $time);
        assertErrors++;
    end

    validFallCheck: assert property (@(posedge clk) disable iff (!rstN)
        !instValid |=> !resultValid)
    else begin
        $display("CHECK FAILED at %0t: resultValid without instValid", $time);
        assertErrors++;
    end

    function automatic void predict(input aluPkg::aluCmd_e cmd, input logic [Msb:0] a,
                                    input logic [Msb:0] b, output logic [Msb:0] res,
                                    output aluPkg::aluFlags_t fl);
        logic [`DATA_WIDTH:0] wide;
        res  = '0;
        fl   = '0;
        wide = {1'b0, a} + {1'b0, ~b} + (`DATA_WIDTH+1)'(1);
        case (cmd)
            aluPkg::ADD: begin
                wide        = {1'b0, a} + {1'b0, b};
                res         = wide[Msb:0];
                fl.carryOut = wide[`DATA_WIDTH];
                fl.overflow = (a[Msb] == b[Msb]) && (res[Msb] != a[Msb]);
            end
            aluPkg::SUB: begin
                res         = wide[Msb:0];
                fl.carryOut = wide[`DATA_WIDTH];
                fl.overflow = (a[Msb] != b[Msb]) && (res[Msb] != a[Msb]);
            end
            aluPkg::SLT: begin
                res         = ($signed(a) < $signed(b)) ? `DATA_WIDTH'(1) : '0;
                fl.carryOut = wide[`DATA_WIDTH];
            end
            aluPkg::XOR:  res = a ^ b;
            aluPkg::AND:  res = a & b;
            aluPkg::NAND: res = ~(a & b);
            aluPkg::NOR:  res = ~(a | b);
            default:      res = a | b;
        endcase
        fl.zero = (res == '0);
    endfunction

    task automatic driveInst(input aluPkg::aluCmd_e cmd, input logic [4:0] rs,
                             input logic [4:0] rt, input logic [4:0] rd);
        logic [Msb:0]      res;
        aluPkg::aluFlags_t fl;
        predict(cmd, modelRegs[rs], modelRegs[rt], res, fl);
        inst.command = cmd;
        inst.rs      = rs;
        inst.rt      = rt;
        inst.rd      = rd;
        instValid    = 1'b1;
        loadValid    = 1'b0;
        expResult    = res;
        expFlags     = fl;
        if (rd != '0) begin
            modelRegs[rd] = res;
        end
        issuedCount++;
    endtask

    task automatic issue(input aluPkg::aluCmd_e cmd, input logic [4:0] rs,
                         input logic [4:0] rt, input logic [4:0] rd);
        @(negedge clk);
        driveInst(cmd, rs, rt, rd);
    endtask

    // the load goes out in the same cycle and is expected to be dropped
    task automatic issueWithLoad(input aluPkg::aluCmd_e cmd, input logic [4:0] rd,
                                 input logic [4:0] addr, input logic [Msb:0] data);
        @(negedge clk);
        driveInst(cmd, 5'd1, 5'd2, rd);
        loadValid = 1'b1;
        loadAddr  = addr;
        loadData  = data;
    endtask

    task automatic loadReg(input logic [4:0] addr, input logic [Msb:0] data);
        @(negedge clk);
        instValid = 1'b0;
        loadValid = 1'b1;
        loadAddr  = addr;
        loadData  = data;
        if (addr != '0) begin
            modelRegs[addr] = data;
        end
    endtask

    task automatic awaitResult();
        int waited;
        waited = 0;
        @(negedge clk);
        instValid = 1'b0;
        loadValid = 1'b0;
        while (!resultValid && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!resultValid) begin
            $display("no result pulse within %0d cycles at %0t", WaitLimit, $time);
            waitErrors++;
        end
        // one more edge so the check on the last result has been evaluated
        @(negedge clk);
    endtask

    task automatic endTest(input string name);
        int total;
        total = assertErrors + waitErrors;
        $display("test %s finished with %0d errors", name, total - errorBase);
        errorBase = total;
        testCount++;
    endtask

    function automatic logic [4:0] srcReg();
        return 5'($urandom_range(1, 15));
    endfunction

    function automatic logic [4:0] dstReg();
        return 5'($urandom_range(16, 31));
    endfunction

    initial begin
        int               waited;
        int               total;
        logic [4:0]       prevRd;
        logic [4:0]       rd;
        aluPkg::aluCmd_e  logicCmds [5];
        void'($urandom(32'he5055fc1));
        logicCmds = '{aluPkg::XOR, aluPkg::AND, aluPkg::NAND, aluPkg::NOR, aluPkg::OR};
        instValid = 1'b0;
        inst = '0;
        loadValid = 1'b0;
        loadAddr = '0;
        loadData = '0;
        expResult = '0;
        expFlags = '0;
        assertErrors = 0;
        waitErrors = 0;
        errorBase = 0;
        issuedCount = 0;
        testCount = 0;
        for (int idx = 0; idx < `REG_COUNT; idx++) begin
            modelRegs[idx] = '0;
        end

        waited = 0;
        while (rstN !== 1'b1 && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (rstN !== 1'b1) begin
            $display("reset was never released");
            waitErrors++;
        end
        issue(aluPkg::ADD, 5'd1, 5'd2, 5'd3);
        awaitResult();
        endTest("reset");

        for (int idx = 1; idx <= 8; idx++) begin
            loadReg(5'(idx), $urandom());
        end
        loadReg(5'd9, 32'h7fff_ffff);
        loadReg(5'd10, 32'h0000_0001);
        loadReg(5'd11, 32'h8000_0000);
        loadReg(5'd12, 32'h0f0f_1234);
        issue(aluPkg::ADD, 5'd9, 5'd10, 5'd16);
        issue(aluPkg::SUB, 5'd11, 5'd10, 5'd17);
        issue(aluPkg::ADD, 5'd11, 5'd11, 5'd18);
        for (int idx = 0; idx < 10; idx++) begin
            issue(aluPkg::aluCmd_e'(3'($urandom_range(0, 1))), srcReg(), srcReg(), dstReg());
        end
        awaitResult();
        endTest("arithmetic");

        issue(aluPkg::AND, 5'd1, 5'd0, 5'd16);
        for (int idx = 0; idx < 15; idx++) begin
            issue(logicCmds[$urandom_range(0, 4)], srcReg(), srcReg(), dstReg());
        end
        awaitResult();
        endTest("logic");

        issue(aluPkg::SLT, 5'd1, 5'd1, 5'd16);
        issue(aluPkg::SLT, 5'd11, 5'd10, 5'd17);
        issue(aluPkg::SLT, 5'd10, 5'd11, 5'd18);
        issue(aluPkg::SLT, 5'd11, 5'd9, 5'd19);
        issue(aluPkg::SLT, 5'd9, 5'd11, 5'd20);
        for (int idx = 0; idx < 6; idx++) begin
            issue(aluPkg::SLT, srcReg(), srcReg(), dstReg());
        end
        awaitResult();
        endTest("slt");

        loadReg(5'd0, $urandom());
        issue(aluPkg::OR, 5'd0, 5'd0, 5'd16);
        issue(aluPkg::ADD, 5'd9, 5'd10, 5'd0);
        issue(aluPkg::NOR, 5'd0, 5'd0, 5'd17);
        issueWithLoad(aluPkg::OR, 5'd18, 5'd12, $urandom());
        issue(aluPkg::OR, 5'd12, 5'd12, 5'd19);
        // the writeback that won the port must hold the instruction result
        issue(aluPkg::OR, 5'd18, 5'd18, 5'd20);
        awaitResult();
        endTest("register zero and priority");

        prevRd = 5'd16;
        for (int idx = 0; idx < 24; idx++) begin
            rd = dstReg();
            issue(aluPkg::aluCmd_e'(3'($urandom_range(0, 7))), prevRd, srcReg(), rd);
            prevRd = rd;
        end
        awaitResult();
        endTest("back to back");

        total = assertErrors + waitErrors;
        $display("tests %0d, instructions %0d, errors %0d", testCount, issuedCount, total);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
logic/aluPkg.sv
logic/aluSlice.sv
logic/aluCore.sv
logic/regFile.sv
logic/executeStage.sv
testbench/clockGen.sv
testbench/executeStageTb.sv
